//--- Makefile
# Verilator build and run of the interval timer testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/100ps
TOP       ?= pit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
logic/pit_pkg.sv
logic/pit_timebase.sv
logic/pit_counter.sv
logic/pit.sv
testbench/pit_tb.sv

//--- logic/pit.sv
// 8254-style programmable interval timer on i/o ports 040h-043h and 61h
// channel 0 drives irq, channel 1 runs internally, channel 2 is gated
// by port 61h and drives the speaker; reads are registered and valid
// the cycle after the counted read strobe
`timescale 1ns/100ps
`default_nettype none

module pit (
    input  wire                    clk,
    input  wire                    rst_n,
    output logic                   irq,
    // cpu i/o slave
    input  wire pit_pkg::io_addr_t io_address,
    input  wire                    io_read,
    output pit_pkg::byte_t         io_readdata,
    input  wire                    io_write,
    input  wire pit_pkg::byte_t    io_writedata,
    // port 61h
    input  wire                    speaker_61h_read,
    output pit_pkg::byte_t         speaker_61h_readdata,
    input  wire                    speaker_61h_write,
    input  wire pit_pkg::byte_t    speaker_61h_writedata,
    // speaker
    output logic                   speaker_enable,
    output logic                   speaker_out,
    // management register 0 bits 7:0 hold the divisor
    input  wire                    mgmt_address,
    input  wire                    mgmt_write,
    input  wire [31:0]             mgmt_writedata
);
    import pit_pkg::*;

    logic       count_clock;
    logic       refresh_toggle;
    logic       speaker_gate;
    logic       io_read_last;
    logic       read_valid;     // counted read
    logic       ctrl_write;
    logic       read_back;
    access_t    ctrl_access;
    logic [2:0] chan_gate;
    logic [2:0] chan_out;
    byte_t      chan_data [3];
    byte_t      readdata_next;

    pit_timebase u_timebase (
        .clk            (clk),
        .rst_n          (rst_n),
        .mgmt_write     (mgmt_write),
        .mgmt_address   (mgmt_address),
        .mgmt_writedata (mgmt_writedata),
        .count_clock    (count_clock),
        .refresh_toggle (refresh_toggle)
    );

    // ----------------------------------------------------------------------
    // a held io_read counts only every second cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_read_last <= 1'b0;
        end else begin
            io_read_last <= io_read_last ? 1'b0 : io_read;
        end
    end

    assign read_valid = io_read && !io_read_last;

    // ----------------------------------------------------------------------
    // control word decode and channels
    assign ctrl_write  = io_write && io_address == ADDR_CONTROL;
    assign read_back   = io_writedata[7:6] == 2'b11;
    assign ctrl_access = access_t'(io_writedata[5:4]);
    assign chan_gate   = {speaker_gate, 1'b1, 1'b1};
    assign irq         = chan_out[0];
    assign speaker_out = chan_out[2];

    for (genvar i = 0; i < 3; i++) begin : g_chan
        logic sel_hit;  // sc field names this channel
        logic rb_hit;   // read-back names this channel

        assign sel_hit = io_writedata[7:6] == 2'(i);
        assign rb_hit  = read_back && io_writedata[i + 1];

        pit_counter u_counter (
            .clk              (clk),
            .rst_n            (rst_n),
            .count_clock      (count_clock),
            .gate             (chan_gate[i]),
            .out              (chan_out[i]),
            .data_in          (io_writedata),
            .set_control_mode (ctrl_write && sel_hit && ctrl_access != latch_cmd),
            .latch_count      (ctrl_write && ((sel_hit && ctrl_access == latch_cmd) ||
                                              (rb_hit && !io_writedata[5]))),
            .latch_status     (ctrl_write && rb_hit && !io_writedata[4]),
            .write            (io_write && io_address == io_addr_t'(i)),
            .read             (read_valid && io_address == io_addr_t'(i)),
            .data_out         (chan_data[i])
        );
    end

    // ----------------------------------------------------------------------
    // read data is registered and zero outside a counted read
    always_comb begin
        readdata_next = '0;
        if (read_valid) begin
            case (io_address)
                2'd0:    readdata_next = chan_data[0];
                2'd1:    readdata_next = chan_data[1];
                2'd2:    readdata_next = chan_data[2];
                default: readdata_next = '0;  // control port
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            io_readdata <= '0;
        end else begin
            io_readdata <= readdata_next;
        end
    end

    // ----------------------------------------------------------------------
    // port 61h
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speaker_gate   <= 1'b0;
            speaker_enable <= 1'b0;
        end else if (speaker_61h_write) begin
            speaker_gate   <= speaker_61h_writedata[0];
            speaker_enable <= speaker_61h_writedata[1];
        end
    end

    assign speaker_61h_readdata = {2'b00, speaker_out, refresh_toggle,
                                   2'b00, speaker_enable, speaker_gate};

endmodule

`default_nettype wire

//--- logic/pit_counter.sv
// one 8254 counter channel
// modes 0, 2 and 3 (1, 4 and 5 count as mode 0), lsb/msb/lsb_msb access,
// count latch and status latch; acts on the falling edge of count_clock
// as seen one clk later, decrementing while gate is high
`timescale 1ns/100ps
`default_nettype none

module pit_counter (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 count_clock,
    input  wire                 gate,
    output logic                out,
    input  wire pit_pkg::byte_t data_in,
    input  wire                 set_control_mode,
    input  wire                 latch_count,
    input  wire                 latch_status,
    input  wire                 write,
    input  wire                 read,
    output pit_pkg::byte_t      data_out
);
    import pit_pkg::*;

    // ----------------------------------------------------------------------
    // state
    logic [2:0]  mode;            // as written, reported in status
    access_t     access;
    logic        bcd;             // stored and reported only
    load_state_t load_state;

    count_t      initial_count;   // assembled from data_in
    count_t      counter;         // counting element
    count_t      reload_value;
    count_t      latched_count;
    count_t      read_source;
    byte_t       status_byte;
    logic        count_latched;
    logic        status_latched;
    logic        read_msb;        // next lsb_msb read gives the high byte
    logic        null_count;
    logic        load_pending;    // new count not yet in the counting element
    logic        running;
    logic        clock_last;
    logic        clock_fall;
    logic        rate_mode;
    logic        square_mode;
    logic        periodic;
    logic        reload_point;
    logic        load_out;        // out level after a load
    logic        do_load;
    logic        write_done;      // last byte of a count written

    // 6 and 7 alias to 2 and 3
    assign rate_mode    = mode[1:0] == MODE_RATE[1:0];
    assign square_mode  = mode[1:0] == MODE_SQUARE[1:0];
    assign periodic     = rate_mode | square_mode;
    assign clock_fall   = clock_last & ~count_clock;
    assign reload_point = rate_mode ? (counter == 16'd1) : (counter == 16'd2);
    assign load_out     = square_mode ? (~running | ~out) : periodic;  // mode 3 toggles
    assign write_done   = write && (access != lsb_msb || load_state == wait_msb);

    // mode 0 loads a new count at once, periodic modes at the end of a cycle
    assign do_load = clock_fall && load_state == counting &&
                     (periodic ? (gate && (!running || reload_point)) : load_pending);

    always_comb begin
        reload_value = initial_count;
        if (square_mode) begin
            reload_value = {initial_count[15:1], 1'b0};  // counts by 2
            if (initial_count[0] && load_out) begin
                reload_value = reload_value + 16'd2;      // odd count gets the longer high half
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clock_last <= 1'b0;
        end else begin
            clock_last <= count_clock;
        end
    end

    // ----------------------------------------------------------------------
    // control word and count bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode   <= MODE_TERMINAL;
            access <= lsb_msb;
            bcd    <= 1'b0;
        end else if (set_control_mode) begin
            mode   <= data_in[3:1];
            access <= access_t'(data_in[5:4]);
            bcd    <= data_in[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_state <= no_count;
        end else if (set_control_mode) begin
            load_state <= no_count;
        end else if (write_done) begin
            load_state <= counting;
        end else if (write) begin
            load_state <= wait_msb;  // lsb of an lsb_msb pair
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            case (access)
                lsb_only: initial_count <= {8'h00, data_in};
                msb_only: initial_count <= {data_in, 8'h00};
                default: begin
                    if (load_state == wait_msb) begin
                        initial_count[15:8] <= data_in;
                    end else begin
                        initial_count[7:0] <= data_in;
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // counting element and out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter      <= '0;
            running      <= 1'b0;
            out          <= 1'b0;
            load_pending <= 1'b0;
            null_count   <= 1'b1;
        end else begin
            if (do_load) begin
                counter      <= reload_value;
                running      <= 1'b1;
                out          <= load_out;
                load_pending <= 1'b0;
                null_count   <= 1'b0;
            end else if (clock_fall && running && gate) begin
                counter <= square_mode ? counter - 16'd2 : counter - 16'd1;
                if (!periodic && counter == 16'd1) begin
                    out <= 1'b1;  // terminal count
                end
                if (rate_mode && counter == 16'd2) begin
                    out <= 1'b0;  // low for the last count
                end
            end
            if (periodic && !gate) begin
                running <= 1'b0;  // restart from the initial count on gate high
                out     <= 1'b1;
            end
            if (write_done) begin
                load_pending <= 1'b1;
                null_count   <= 1'b1;
            end
            if (set_control_mode) begin
                running      <= 1'b0;
                load_pending <= 1'b0;
                null_count   <= 1'b1;
                out          <= data_in[2];  // modes 2 and 3 idle high and the others low
            end
        end
    end

    // ----------------------------------------------------------------------
    // latches and read sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_latched  <= 1'b0;
            status_latched <= 1'b0;
            read_msb       <= 1'b0;
        end else if (set_control_mode) begin
            count_latched  <= 1'b0;
            status_latched <= 1'b0;
            read_msb       <= 1'b0;
        end else begin
            if (latch_count) begin
                count_latched <= 1'b1;  // repeat latch keeps the first value
            end
            if (latch_status) begin
                status_latched <= 1'b1;
            end
            if (read) begin
                if (status_latched) begin
                    status_latched <= 1'b0;  // status goes out first
                end else begin
                    if (access == lsb_msb) begin
                        read_msb <= ~read_msb;
                    end
                    if (access != lsb_msb || read_msb) begin
                        count_latched <= 1'b0;  // released after the last byte
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (latch_count && !count_latched) begin
            latched_count <= counter;
        end
        if (latch_status && !status_latched) begin
            status_byte <= {out, null_count, access, mode, bcd};
        end
    end

    assign read_source = count_latched ? latched_count : counter;

    always_comb begin
        if (status_latched) begin
            data_out = status_byte;
        end else if (access == msb_only || (access == lsb_msb && read_msb)) begin
            data_out = read_source[15:8];
        end else begin
            data_out = read_source[7:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/pit_pkg.sv
// shared types and constants for the 8254-style interval timer
// imported by the timebase, the counter channels and the top level
`default_nettype none

package pit_pkg;

    // ----------------------------------------------------------------------
    // widths with a meaning
    typedef logic [7:0]  byte_t;     // one i/o data byte
    typedef logic [1:0]  io_addr_t;  // offset within 040h-043h
    typedef logic [15:0] count_t;    // counter value, 0 means 65536
    typedef logic [7:0]  divisor_t;  // clk cycles per count clock

    // ----------------------------------------------------------------------
    // constants
    localparam divisor_t DIVISOR_RESET = 8'd25;  // 1.193 MHz from a 30 MHz-ish clk
    localparam int       REFRESH_TICKS = 36;     // half periods per refresh toggle
    localparam io_addr_t ADDR_CONTROL  = 2'd3;   // control word port 043h

    localparam logic [2:0] MODE_TERMINAL = 3'd0;  // interrupt on terminal count
    localparam logic [2:0] MODE_RATE     = 3'd2;  // rate generator
    localparam logic [2:0] MODE_SQUARE   = 3'd3;  // square wave

    // rw field of the control word
    typedef enum logic [1:0] {
        latch_cmd = 2'b00,
        lsb_only  = 2'b01,
        msb_only  = 2'b10,
        lsb_msb   = 2'b11
    } access_t;

    // count loading sequence
    typedef enum logic [1:0] {
        no_count = 2'd0,  // control written, no count yet
        wait_msb = 2'd1,  // lsb in, msb pending
        counting = 2'd2   // full count available
    } load_state_t;

endpackage

`default_nettype wire

//--- logic/pit_timebase.sv
// count clock generator for the interval timer
// steps by 2 per clk up to the divisor, so one count clock period is
// twice (ceil(d/2) + 1) clk cycles; also makes the port 61h refresh bit
`timescale 1ns/100ps
`default_nettype none

module pit_timebase (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        mgmt_write,
    input  wire        mgmt_address,
    input  wire [31:0] mgmt_writedata,
    output logic       count_clock,
    output logic       refresh_toggle
);
    import pit_pkg::*;

    divisor_t   divisor;      // mgmt register 0
    divisor_t   step;
    logic       wrap;         // half period done
    logic [5:0] refresh_cnt;  // wraps per refresh half period

    assign wrap = step >= divisor;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divisor <= DIVISOR_RESET;
        end else if (mgmt_write && !mgmt_address) begin
            divisor <= mgmt_writedata[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step        <= '0;
            count_clock <= 1'b0;
        end else if (wrap) begin
            step        <= '0;
            count_clock <= ~count_clock;  // one half period per wrap
        end else begin
            step <= step + 8'd2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt    <= '0;
            refresh_toggle <= 1'b0;
        end else if (wrap) begin
            if (refresh_cnt == 6'(REFRESH_TICKS - 1)) begin
                refresh_cnt    <= '0;
                refresh_toggle <= ~refresh_toggle;
            end else begin
                refresh_cnt <= refresh_cnt + 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/pit_tb.sv
// testbench for the 8254-style interval timer
// programs the channels and port 61h with random values from a fixed seed
// and checks status, latches, irq timing, the speaker wave and port 61h
// against the count clock timing rules
`timescale 1ns/100ps
`default_nettype none

module pit_tb;
    import pit_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 5;    // after the rising edge
    localparam int NUM_TRIALS      = 6;
    localparam int MAX_COUNT       = 40;   // largest mode 0 count
    localparam int MAX_PERIOD      = 62;   // count period at divisor 60
    localparam int WATCHDOG_CYCLES = 8 + NUM_TRIALS * MAX_COUNT * MAX_PERIOD * 8;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        irq;
    io_addr_t    io_address;
    logic        io_read;
    byte_t       io_readdata;
    logic        io_write;
    byte_t       io_writedata;
    logic        speaker_61h_read;
    byte_t       speaker_61h_readdata;
    logic        speaker_61h_write;
    byte_t       speaker_61h_writedata;
    logic        speaker_enable;
    logic        speaker_out;
    logic        mgmt_address;
    logic        mgmt_write;
    logic [31:0] mgmt_writedata;

    integer seed   = 32'hc876a38f;
    int     errors = 0;
    int     checks = 0;
    int     period;                        // count clock period in clk cycles

    always #(CLK_PERIOD / 2) clk = ~clk;

    pit DUT (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .irq                   (irq),
        .io_address            (io_address),
        .io_read               (io_read),
        .io_readdata           (io_readdata),
        .io_write              (io_write),
        .io_writedata          (io_writedata),
        .speaker_61h_read      (speaker_61h_read),
        .speaker_61h_readdata  (speaker_61h_readdata),
        .speaker_61h_write     (speaker_61h_write),
        .speaker_61h_writedata (speaker_61h_writedata),
        .speaker_enable        (speaker_enable),
        .speaker_out           (speaker_out),
        .mgmt_address          (mgmt_address),
        .mgmt_write            (mgmt_write),
        .mgmt_writedata        (mgmt_writedata)
    );

    // ----------------------------------------------------------------------
    // helpers
    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % $unsigned(span));
    endfunction

    // two half periods of ceil(d/2) + 1 clks each
    function automatic int count_period(input int divisor);
        return 2 * ((divisor + 1) / 2 + 1);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic step_clk(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    task automatic io_write_byte(input io_addr_t addr, input byte_t data);
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        step_clk(1);
        io_write     = 1'b0;
    endtask

    task automatic io_read_byte(input io_addr_t addr, output byte_t data);
        io_address = addr;
        io_read    = 1'b1;
        step_clk(1);
        io_read    = 1'b0;
        data       = io_readdata;          // registered after the strobe
        step_clk(1);
        compare_value("readdata after read", 0, 32'(io_readdata));
    endtask

    // io_read held two cycles counts as one read
    task automatic io_read_held(input io_addr_t addr, output byte_t data);
        io_address = addr;
        io_read    = 1'b1;
        step_clk(1);
        data = io_readdata;
        step_clk(1);
        compare_value("readdata in held cycle", 0, 32'(io_readdata));
        io_read = 1'b0;
        step_clk(1);
    endtask

    task automatic write_61h(input byte_t data);
        speaker_61h_writedata = data;
        speaker_61h_write     = 1'b1;
        step_clk(1);
        speaker_61h_write     = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // behaviors
    task automatic status_readback();
        logic [1:0] ch;
        access_t    rw;
        logic [2:0] mode;
        logic       bcd;
        logic [2:0] others;
        byte_t      status;
        byte_t      expected;
        ch     = 2'(rand_range(0, 2));
        rw     = access_t'(2'(rand_range(1, 3)));
        mode   = 3'(rand_range(0, 5));
        bcd    = 1'(rand_range(0, 1));
        others = 3'(rand_range(0, 7));     // extra channels in the read-back
        io_write_byte(ADDR_CONTROL, {ch, rw, mode, bcd});
        io_write_byte(ADDR_CONTROL, {2'b11, 1'b1, 1'b0, others | (3'b001 << ch), 1'b0});
        io_read_byte(ch, status);
        // out idles high in modes 2 and 3 and low in the rest
        // no count written yet so null count is set
        expected = {(mode == MODE_RATE || mode == MODE_SQUARE), 1'b1, rw, mode, bcd};
        compare_value("status byte", 32'(expected), 32'(status));
    endtask

    task automatic count_latch_sequence();
        logic [1:0] ch;
        int         n;
        byte_t      lo;
        byte_t      hi;
        int         first;
        int         second;
        int         clks;
        int         steps;
        time        t_first;
        ch = 2'(rand_range(0, 1));
        n  = rand_range(300, 2299);
        io_write_byte(ADDR_CONTROL, {ch, 2'b11, MODE_RATE, 1'b0});
        io_write_byte(ch, 8'(n));
        io_write_byte(ch, 8'(n >> 8));
        step_clk(period + 2 + rand_range(0, 63));  // past the first load
        t_first = $time;
        io_write_byte(ADDR_CONTROL, {ch, 2'b00, 4'b0000});  // count latch
        step_clk(rand_range(0, 63));                        // latch must hold
        io_read_held(ch, lo);
        io_read_byte(ch, hi);
        first = int'({hi, lo});
        compare_value($sformatf("latched count %0d within 1..%0d", first, n), 1,
                      32'(first >= 1 && first <= n));
        clks = int'(($time - t_first) / CLK_PERIOD);
        io_write_byte(ADDR_CONTROL, {ch, 2'b00, 4'b0000});
        io_read_byte(ch, lo);
        io_read_byte(ch, hi);
        second = int'({hi, lo});
        steps  = (first - second + n) % n;  // mode 2 cycles over n values
        compare_value($sformatf("latch delta %0d over %0d clks", steps, clks), 1,
                      32'(steps >= clks / period && steps <= (clks + period - 1) / period));
    endtask

    task automatic terminal_count_irq();
        int  divisor;
        int  n;
        int  waited;
        int  rise;
        int  nominal;
        time t_load;
        divisor        = 2 * rand_range(4, 30);
        mgmt_address   = 1'b0;
        mgmt_writedata = 32'(divisor);
        mgmt_write     = 1'b1;
        step_clk(1);
        mgmt_write     = 1'b0;
        step_clk(2 * period);              // old half period runs out
        period = count_period(divisor);
        n = rand_range(5, MAX_COUNT);
        io_write_byte(ADDR_CONTROL, 8'h30);  // channel 0, lsb_msb, mode 0
        compare_value("irq after control word", 0, 32'(irq));
        io_write_byte(2'd0, 8'(n));
        t_load = $time;
        io_write_byte(2'd0, 8'h00);
        waited = 0;
        while (irq === 1'b0 && waited < (n + 2) * period) begin
            step_clk(1);
            waited++;
        end
        if (irq !== 1'b1) begin
            errors++;
            $display("irq did not rise within %0d clks after a count of %0d", waited, n);
        end else begin
            rise    = int'(($time - t_load) / CLK_PERIOD) - 1;  // edges after msb write
            nominal = n * period;
            compare_value($sformatf("irq rise after %0d clks, nominal %0d", rise, nominal),
                          1, 32'(rise >= nominal - period && rise <= nominal + period));
        end
    endtask

    task automatic speaker_square_wave();
        int   n;
        int   rises;
        int   waited;
        int   lows;
        logic last;
        time  t_first;
        n = rand_range(4, 24);
        write_61h(8'h03);                    // gate and enable
        io_write_byte(ADDR_CONTROL, 8'hb6);  // channel 2, lsb_msb, mode 3
        io_write_byte(2'd2, 8'(n));
        io_write_byte(2'd2, 8'h00);
        rises   = 0;
        waited  = 0;
        t_first = 0;
        last    = speaker_out;
        while (rises < 4 && waited < 6 * (n + 2) * period) begin
            step_clk(1);
            waited++;
            if (last === 1'b0 && speaker_out === 1'b1) begin
                if (rises == 0) begin
                    t_first = $time;
                end
                rises++;
            end
            last = speaker_out;
        end
        if (rises < 4) begin
            errors++;
            $display("speaker_out stopped toggling, %0d rising edges seen", rises);
        end else begin
            compare_value("three square wave periods", 3 * n * period,
                          int'(($time - t_first) / CLK_PERIOD));
        end
        // drop the gate in the low half so the forced high level shows
        waited = 0;
        while (speaker_out !== 1'b0 && waited < n * period) begin
            step_clk(1);
            waited++;
        end
        write_61h(8'h02);                    // gate low
        step_clk(1);                         // out forced high one clk later
        lows = 0;
        repeat (n * period) begin
            if (speaker_out !== 1'b1) begin
                lows++;
            end
            step_clk(1);
        end
        compare_value("speaker_out low samples with gate low", 0, lows);
    endtask

    task automatic port_61h_register();
        byte_t value;
        byte_t readback;
        logic  out_now;
        logic  refresh;
        int    limit;
        int    waited;
        time   t_flip;
        value = 8'(rand_range(0, 255));
        write_61h(value);
        compare_value("speaker_enable", 32'(value[1]), 32'(speaker_enable));
        speaker_61h_read = 1'b1;
        readback         = speaker_61h_readdata;
        out_now          = speaker_out;
        step_clk(1);
        speaker_61h_read = 1'b0;
        // bit 4 is free running and timed below
        compare_value("port 61h readback",
                      32'({2'b00, out_now, 1'b0, 2'b00, value[1:0]}),
                      32'(readback & 8'hef));
        // bit 4 half period is REFRESH_TICKS half periods of the count clock
        limit   = REFRESH_TICKS * period / 2 + period;
        refresh = speaker_61h_readdata[4];
        waited  = 0;
        while (speaker_61h_readdata[4] === refresh && waited < limit) begin
            step_clk(1);
            waited++;
        end
        t_flip  = $time;
        refresh = speaker_61h_readdata[4];
        waited  = 0;
        while (speaker_61h_readdata[4] === refresh && waited < limit) begin
            step_clk(1);
            waited++;
        end
        compare_value("refresh bit half period", REFRESH_TICKS * period / 2,
                      int'(($time - t_flip) / CLK_PERIOD));
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    initial begin
        rst_n                 = 1'b0;
        io_address            = '0;
        io_read               = 1'b0;
        io_write              = 1'b0;
        io_writedata          = '0;
        speaker_61h_read      = 1'b0;
        speaker_61h_write     = 1'b0;
        speaker_61h_writedata = '0;
        mgmt_address          = 1'b0;
        mgmt_write            = 1'b0;
        mgmt_writedata        = '0;
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n  = 1'b1;
        period = count_period(int'(DIVISOR_RESET));  // 28 clks

        compare_value("irq after reset", 0, 32'(irq));
        compare_value("speaker_out after reset", 0, 32'(speaker_out));
        compare_value("speaker_enable after reset", 0, 32'(speaker_enable));
        compare_value("io_readdata after reset", 0, 32'(io_readdata));
        compare_value("port 61h after reset", 0, 32'(speaker_61h_readdata));

        for (int trial = 0; trial < NUM_TRIALS; trial++) begin
            status_readback();
            count_latch_sequence();
            terminal_count_irq();              // picks a new divisor
            speaker_square_wave();
            port_61h_register();
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run limit from the trial count and the longest count period
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d clk cycles, run stopped", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
